//--- amo_resolver.f
verilog/amo_pkg.sv
verilog/obi_bus_pkg.sv
verilog/amo_sequencer.sv
verilog/amo_alu.sv
verilog/lrsc_reservation.sv
verilog/resp_path.sv
verilog/amo_resolver_top.sv
dv/amo_resolver_assert.sv
dv/amo_resolver_tb.sv

//--- dv/amo_resolver_assert.sv
// Handshake assertions for the request sequencer
// Bound into every amo_sequencer instance
`timescale 1ns/1ps

module amo_resolver_assert import obi_bus_pkg::*; (
  input logic  clk_i,
  input logic  rst_ni,
  input logic  req_i,
  input addr_t addr_i,
  input logic  we_i,
  input data_t wdata_i,
  input id_t   aid_i,
  input atop_u atop_i,
  input logic  gnt_o,
  input logic  wb_active_o,
  input logic  mem_gnt_i,
  input data_t mem_wdata_o
);

  // Write-back word holds while the memory keeps it waiting
  wb_data_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wb_active_o && !mem_gnt_i) |=> $stable(mem_wdata_o))
    else $error("Write-back data changed before it was granted");

  // A waiting request may not change
  held_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_i && !gnt_o) |=> (req_i && $stable(addr_i) && $stable(we_i) &&
                           $stable(wdata_i) && $stable(aid_i) && $stable(atop_i)))
    else $error("Request changed or dropped before it was granted");

endmodule

bind amo_sequencer amo_resolver_assert i_assert (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .req_i       (req_i),
  .addr_i      (addr_i),
  .we_i        (we_i),
  .wdata_i     (wdata_i),
  .aid_i       (aid_i),
  .atop_i      (atop_i),
  .gnt_o       (gnt_o),
  .wb_active_o (wb_active_o),
  .mem_gnt_i   (mem_gnt_i),
  .mem_wdata_o (mem_wdata_o)
);

//--- dv/amo_resolver_tb.sv
// Testbench for the atomic operation resolver
// Random traffic against a memory model, checked by a reference model
`timescale 1ns/1ps

module amo_resolver_tb import obi_bus_pkg::*, amo_pkg::*; ();

  localparam int ClkPeriod   = 4;
  localparam int NumRequests = 2000;
  localparam int WatchdogNs  = NumRequests * 8 * ClkPeriod;

  logic  clk_i, rst_ni;
  logic  req_i, we_i, gnt_o;
  addr_t addr_i, mem_addr_o;
  data_t wdata_i, rdata_o, mem_wdata_o, mem_rdata_i;
  id_t   aid_i, rid_o, mem_aid_o;
  atop_u atop_i;
  logic  rvalid_o, exokay_o;
  logic  mem_req_o, mem_we_o, mem_gnt_i, mem_rvalid_i;

  // Memory model and reference model state
  data_t mem_model [16];
  data_t ref_mem [16];
  logic  res_valid;
  addr_t res_addr;
  id_t   res_id;
  data_t exp_data_q [$];
  id_t   exp_id_q [$];
  logic  exp_ok_q [$];

  logic        resp_due, mem_resp_due, mem_busy, req_pending, busy;
  logic        wb_due;
  id_t         wb_aid;
  data_t       mem_rd_next;
  id_t         last_lr_id;
  addr_t       last_lr_addr;
  int          issued, accept_count, resp_count, sc_ok_count, sc_fail_count;

  amo_resolver_top dut_i (.*);

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  task automatic stop_on_error();
    $display("Checks failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // ------------------------------
  // Compare tasks
  // ------------------------------
  task automatic check_data(string name, data_t act, data_t exp);
    if (act !== exp) begin
      $display("Error at %0t: %s is %h, expected %h", $time, name, act, exp);
      stop_on_error();
    end
  endtask

  task automatic check_id(string name, id_t act, id_t exp);
    if (act !== exp) begin
      $display("Error at %0t: %s is %h, expected %h", $time, name, act, exp);
      stop_on_error();
    end
  endtask

  task automatic check_exokay(string name, logic act, logic exp);
    if (act !== exp) begin
      $display("Error at %0t: %s is %b, expected %b", $time, name, act, exp);
      stop_on_error();
    end
  endtask

  // New word that each read-modify-write atomic stores
  function automatic data_t amo_apply(amo_op_e op, data_t old, data_t opnd);
    case (op)
      AmoAdd:  return old + opnd;
      AmoXor:  return old ^ opnd;
      AmoAnd:  return old & opnd;
      AmoOr:   return old | opnd;
      AmoMin:  return ($signed(old) < $signed(opnd)) ? old : opnd;
      AmoMax:  return ($signed(old) > $signed(opnd)) ? old : opnd;
      AmoMinu: return (old < opnd) ? old : opnd;
      AmoMaxu: return (old > opnd) ? old : opnd;
      default: return opnd;
    endcase
  endfunction

  // ------------------------------
  // Reference model
  // ------------------------------
  task automatic model_accept();
    logic [3:0] w;
    logic       same_id;
    logic       sc_ok;
    data_t      old;
    amo_op_e    op;
    w       = addr_i[5:2];
    op      = atop_i.op;
    old     = ref_mem[w];
    same_id = (aid_i == res_id);
    exp_id_q.push_back(aid_i);
    if (op == AmoLr) begin
      exp_data_q.push_back(old);
      exp_ok_q.push_back(1'b0);
      if (!res_valid || same_id) begin
        res_valid = 1'b1;
        res_addr  = addr_i;
        res_id    = aid_i;
      end
    end else if (op == AmoSc) begin
      sc_ok = res_valid && same_id && (addr_i == res_addr);
      if (res_valid && same_id) begin
        res_valid = 1'b0;
      end
      if (sc_ok) begin
        ref_mem[w] = wdata_i;
        exp_data_q.push_back('0);
        sc_ok_count++;
      end else begin
        exp_data_q.push_back(data_t'(ScFailValue));
        sc_fail_count++;
      end
      exp_ok_q.push_back(sc_ok);
    end else begin
      // Plain access or read-modify-write, both answer with the old word
      exp_data_q.push_back(old);
      exp_ok_q.push_back(1'b0);
      if (op != AmoNone) begin
        ref_mem[w] = amo_apply(op, old, wdata_i);
      end else if (we_i) begin
        ref_mem[w] = wdata_i;
      end
      if ((we_i || op != AmoNone) && !same_id && (addr_i == res_addr)) begin
        res_valid = 1'b0;
      end
    end
  endtask

  // Everything here is sampled mid-cycle where the DUT is settled
  task automatic sample_cycle();
    logic acc;
    logic fire;
    acc = req_i && gnt_o;
    if (rvalid_o !== resp_due) begin
      if (resp_due) begin
        $display("Error at %0t: no response strobe in the cycle after acceptance", $time);
      end else begin
        $display("Error at %0t: response strobe without an accepted request", $time);
      end
      stop_on_error();
    end
    if (rvalid_o) begin
      check_data("rdata_o", rdata_o, exp_data_q.pop_front());
      check_id("rid_o", rid_o, exp_id_q.pop_front());
      check_exokay("exokay_o", exokay_o, exp_ok_q.pop_front());
      resp_count++;
    end
    resp_due = acc;
    if (acc) begin
      model_accept();
      accept_count++;
      req_pending = 1'b0;
    end
    // Memory model reads before it writes
    fire         = mem_req_o && mem_gnt_i;
    mem_resp_due = fire;
    if (fire) begin
      // Write-back carries the id of its atomic, anything else the request id
      if (wb_due) begin
        check_id("mem_aid_o", mem_aid_o, wb_aid);
        wb_due = 1'b0;
      end else begin
        check_id("mem_aid_o", mem_aid_o, aid_i);
      end
      mem_rd_next = mem_model[mem_addr_o[5:2]];
      if (mem_we_o) begin
        mem_model[mem_addr_o[5:2]] = mem_wdata_o;
      end
    end
    if (acc && atop_i.fields.is_atomic && atop_i.op != AmoLr && atop_i.op != AmoSc) begin
      wb_due = 1'b1;
      wb_aid = aid_i;
    end
    mem_busy = mem_req_o;
  endtask

  task automatic drive_memory();
    mem_gnt_i    = ($urandom % 4) != 0;
    mem_rvalid_i = mem_resp_due;
    mem_rdata_i  = mem_resp_due ? mem_rd_next : '0;
  endtask

  task automatic drive_request();
    logic [31:0] r;
    int unsigned kind;
    if (req_pending) begin
      return;
    end
    req_i = 1'b0;
    if (issued == NumRequests || ($urandom % 5) == 0) begin
      return;
    end
    r            = $urandom;
    kind         = $urandom % 13;
    aid_i        = '0;
    aid_i[1:0]   = r[1:0];
    addr_i       = '0;
    addr_i[3:2]  = r[5:4];
    wdata_i      = $urandom;
    atop_i       = '0;
    case (kind)
      0, 1: atop_i.op = AmoNone;
      2:    atop_i.op = AmoLr;
      3:    atop_i.op = AmoSc;
      4:    atop_i.op = AmoSwap;
      5:    atop_i.op = AmoAdd;
      6:    atop_i.op = AmoXor;
      7:    atop_i.op = AmoAnd;
      8:    atop_i.op = AmoOr;
      9:    atop_i.op = AmoMin;
      10:   atop_i.op = AmoMax;
      11:   atop_i.op = AmoMinu;
      default: atop_i.op = AmoMaxu;
    endcase
    we_i = (kind == 1) || (kind >= 3);
    // Half the SCs aim at the most recent LR
    if (kind == 3 && ($urandom % 2) == 0) begin
      aid_i  = last_lr_id;
      addr_i = last_lr_addr;
    end
    if (kind == 2) begin
      last_lr_id   = aid_i;
      last_lr_addr = addr_i;
    end
    req_i       = 1'b1;
    req_pending = 1'b1;
    issued++;
  endtask

  initial begin
    void'($urandom(26));
    $timeformat(-9, 0, " ns", 0);
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    req_i        = 1'b0;
    addr_i       = '0;
    we_i         = 1'b0;
    wdata_i      = '0;
    aid_i        = '0;
    atop_i       = '0;
    mem_gnt_i    = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_rdata_i  = '0;
    res_valid    = 1'b0;
    res_addr     = '0;
    res_id       = '0;
    last_lr_id   = '0;
    last_lr_addr = '0;
    resp_due     = 1'b0;
    mem_resp_due = 1'b0;
    mem_rd_next  = '0;
    req_pending  = 1'b0;
    wb_due       = 1'b0;
    wb_aid       = '0;
    for (int i = 0; i < 16; i++) begin
      mem_model[i] = $urandom;
      ref_mem[i]   = mem_model[i];
    end
    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    busy   = 1'b1;
    while (busy) begin
      @(negedge clk_i);
      sample_cycle();
      busy = (accept_count < NumRequests) || (exp_data_q.size() != 0) || mem_busy;
      @(posedge clk_i);
      #1;
      drive_memory();
      drive_request();
    end
    for (int i = 0; i < 16; i++) begin
      check_data($sformatf("mem_model[%0d]", i), mem_model[i], ref_mem[i]);
    end
    if (resp_count != accept_count) begin
      $display("Error at %0t: %0d responses for %0d accepted requests",
               $time, resp_count, accept_count);
      stop_on_error();
    end else if (sc_ok_count == 0 || sc_fail_count == 0) begin
      $display("Error at %0t: SC traffic did not cover both success and failure", $time);
      stop_on_error();
    end else begin
      $display("All checks passed");
      $finish;
    end
  end

  // Watchdog sized for the worst case of every request
  initial begin
    #(WatchdogNs);
    $display("Timeout after %0t: the request stream did not complete", $time);
    stop_on_error();
  end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the atomic resolver testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module amo_resolver_tb -f amo_resolver.f -Mdir obj_dir -o amo_resolver_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/amo_resolver_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "All checks passed" "$log"; then
  exit 0
fi
echo "Pass message not found in $log"
exit 1

//--- verilog/amo_alu.sv
// Atomic ALU
// Combines the old memory word with the request operand, one shared
// 33-bit adder serves add and all min/max compares
`timescale 1ns/1ps

module amo_alu import obi_bus_pkg::*, amo_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    mem_rvalid_i,
  input  data_t   mem_rdata_i,
  input  amo_op_e amo_op_i,
  input  data_t   amo_operand_i,
  output data_t   amo_result_o
);

  data_t       old_q;
  data_t       old_word;
  logic [32:0] adder_a, adder_b, adder_sum;
  logic        adder_sub;
  logic        less;

  // Old word, live in the response cycle and held afterwards
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      old_q <= '0;
    end else if (mem_rvalid_i) begin
      old_q <= mem_rdata_i;
    end
  end

  assign old_word = mem_rvalid_i ? mem_rdata_i : old_q;

  // ------------------------------
  // Shared adder
  // ------------------------------
  always_comb begin
    adder_sub = amo_op_i inside {AmoMin, AmoMax, AmoMinu, AmoMaxu};
    // Sign extend for signed compares, zero extend otherwise
    if (amo_op_i inside {AmoMin, AmoMax}) begin
      adder_a = {old_word[31], old_word};
      adder_b = {amo_operand_i[31], amo_operand_i};
    end else begin
      adder_a = {1'b0, old_word};
      adder_b = {1'b0, amo_operand_i};
    end
    if (adder_sub) begin
      adder_b = ~adder_b;
    end
  end

  assign adder_sum = adder_a + adder_b + {32'b0, adder_sub};
  // Sign of old minus operand
  assign less      = adder_sum[32];

  always_comb begin
    unique case (amo_op_i)
      AmoAdd:          amo_result_o = adder_sum[31:0];
      AmoAnd:          amo_result_o = old_word & amo_operand_i;
      AmoOr:           amo_result_o = old_word | amo_operand_i;
      AmoXor:          amo_result_o = old_word ^ amo_operand_i;
      AmoMin, AmoMinu: amo_result_o = less ? old_word : amo_operand_i;
      AmoMax, AmoMaxu: amo_result_o = less ? amo_operand_i : old_word;
      // Swap and anything else stores the operand
      default:         amo_result_o = amo_operand_i;
    endcase
  end

endmodule

//--- verilog/amo_pkg.sv
// Atomic operation definitions
// Opcode encoding, sequencer states and opcode classes
package amo_pkg;

  // Bus atop encoding, top bit set for every atomic
  typedef enum logic [5:0] {
    AmoNone = 6'h00,
    AmoAdd  = 6'h20,
    AmoSwap = 6'h21,
    AmoLr   = 6'h22,
    AmoSc   = 6'h23,
    AmoXor  = 6'h24,
    AmoOr   = 6'h28,
    AmoAnd  = 6'h2C,
    AmoMin  = 6'h30,
    AmoMax  = 6'h34,
    AmoMinu = 6'h38,
    AmoMaxu = 6'h3C
  } amo_op_e;

  typedef enum logic {
    SeqIdle,
    SeqDoAmo
  } seq_state_e;

  // Response word of a failed SC, success returns zero
  localparam int unsigned ScFailValue = 1;

  // Read-modify-write class, resolved into a read and a write-back
  function automatic logic is_rmw(amo_op_e op);
    return op inside {AmoSwap, AmoAdd, AmoXor, AmoAnd, AmoOr,
                      AmoMin, AmoMax, AmoMinu, AmoMaxu};
  endfunction

endpackage

//--- verilog/amo_resolver_top.sv
// Atomic operation resolver
// Sits in front of a single-ported memory and turns atomics into
// read plus write-back sequences, with one LR/SC reservation
`timescale 1ns/1ps

module amo_resolver_top import obi_bus_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  // Subordinate request
  input  logic  req_i,
  input  addr_t addr_i,
  input  logic  we_i,
  input  data_t wdata_i,
  input  id_t   aid_i,
  input  atop_u atop_i,
  output logic  gnt_o,
  // Subordinate response
  output logic  rvalid_o,
  output data_t rdata_o,
  output id_t   rid_o,
  output logic  exokay_o,
  // Manager port
  output logic  mem_req_o,
  output addr_t mem_addr_o,
  output logic  mem_we_o,
  output data_t mem_wdata_o,
  output id_t   mem_aid_o,
  input  logic  mem_gnt_i,
  input  logic  mem_rvalid_i,
  input  data_t mem_rdata_i
);

  logic             accept;
  logic             sc_success;
  data_t            amo_result;
  amo_pkg::amo_op_e amo_op;
  data_t            amo_operand;

  amo_sequencer i_sequencer (
    .clk_i,
    .rst_ni,
    .req_i,
    .addr_i,
    .we_i,
    .wdata_i,
    .aid_i,
    .atop_i,
    .mem_gnt_i,
    .sc_success_i  (sc_success),
    .amo_result_i  (amo_result),
    .gnt_o,
    .accept_o      (accept),
    .wb_active_o   (),
    .amo_op_o      (amo_op),
    .amo_operand_o (amo_operand),
    .mem_req_o,
    .mem_addr_o,
    .mem_we_o,
    .mem_wdata_o,
    .mem_aid_o
  );

  amo_alu i_alu (
    .clk_i,
    .rst_ni,
    .mem_rvalid_i,
    .mem_rdata_i,
    .amo_op_i      (amo_op),
    .amo_operand_i (amo_operand),
    .amo_result_o  (amo_result)
  );

  lrsc_reservation i_reservation (
    .clk_i,
    .rst_ni,
    .accept_i     (accept),
    .addr_i,
    .we_i,
    .aid_i,
    .atop_i,
    .sc_success_o (sc_success)
  );

  resp_path i_resp (
    .clk_i,
    .rst_ni,
    .accept_i     (accept),
    .aid_i,
    .atop_i,
    .sc_success_i (sc_success),
    .mem_rvalid_i,
    .mem_rdata_i,
    .rvalid_o,
    .rdata_o,
    .rid_o,
    .exokay_o
  );

endmodule

//--- verilog/amo_sequencer.sv
// Request sequencer
// Passes plain traffic through and claims the memory port for the
// write-back half of every read-modify-write atomic
`timescale 1ns/1ps

module amo_sequencer import obi_bus_pkg::*, amo_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    req_i,
  input  addr_t   addr_i,
  input  logic    we_i,
  input  data_t   wdata_i,
  input  id_t     aid_i,
  input  atop_u   atop_i,
  input  logic    mem_gnt_i,
  input  logic    sc_success_i,
  input  data_t   amo_result_i,
  output logic    gnt_o,
  output logic    accept_o,
  output logic    wb_active_o,
  output amo_op_e amo_op_o,
  output data_t   amo_operand_o,
  output logic    mem_req_o,
  output addr_t   mem_addr_o,
  output logic    mem_we_o,
  output data_t   mem_wdata_o,
  output id_t     mem_aid_o
);

  seq_state_e state_q, state_d;
  logic       load_amo;
  amo_op_e    op_q;
  addr_t      addr_q;
  id_t        aid_q;
  data_t      operand_q;

  assign wb_active_o   = (state_q == SeqDoAmo);
  assign accept_o      = req_i & gnt_o;
  assign amo_op_o      = op_q;
  assign amo_operand_o = operand_q;

  always_comb begin
    // Default is a straight pass-through
    gnt_o       = mem_gnt_i;
    mem_req_o   = req_i;
    mem_addr_o  = addr_i;
    mem_wdata_o = wdata_i;
    mem_aid_o   = aid_i;
    mem_we_o    = we_i;
    state_d     = state_q;
    load_amo    = 1'b0;

    // LR and atomics read, SC writes only when it holds the reservation
    if (atop_i.fields.is_atomic) begin
      mem_we_o = (atop_i.op == AmoSc) && sc_success_i;
    end

    unique case (state_q)
      SeqIdle: begin
        if (req_i && mem_gnt_i && is_rmw(atop_i.op)) begin
          load_amo = 1'b1;
          state_d  = SeqDoAmo;
        end
      end
      SeqDoAmo: begin
        // Subordinate is blocked until the write-back is granted
        gnt_o       = 1'b0;
        mem_req_o   = 1'b1;
        mem_we_o    = 1'b1;
        mem_addr_o  = addr_q;
        mem_aid_o   = aid_q;
        mem_wdata_o = amo_result_i;
        if (mem_gnt_i) begin
          state_d = SeqIdle;
        end
      end
      default: state_d = SeqIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= SeqIdle;
      op_q    <= AmoNone;
    end else begin
      state_q <= state_d;
      if (load_amo) begin
        op_q <= atop_i.op;
      end
    end
  end

  // Write-back target and operand
  always_ff @(posedge clk_i) begin
    if (load_amo) begin
      addr_q    <= addr_i;
      aid_q     <= aid_i;
      operand_q <= wdata_i;
    end
  end

endmodule

//--- verilog/lrsc_reservation.sv
// LR/SC reservation
// Single reservation with owner id, decides whether an SC may store
`timescale 1ns/1ps

module lrsc_reservation import obi_bus_pkg::*, amo_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  accept_i,
  input  addr_t addr_i,
  input  logic  we_i,
  input  id_t   aid_i,
  input  atop_u atop_i,
  output logic  sc_success_o
);

  logic  res_valid_q, res_valid_d;
  addr_t res_addr_q;
  id_t   res_id_q;
  logic  is_owner;
  logic  is_lr, is_sc;
  logic  place;
  logic  foreign_store;

  assign is_owner = (aid_i == res_id_q);
  assign is_lr    = (atop_i.op == AmoLr);
  assign is_sc    = (atop_i.op == AmoSc);

  // New LR may replace only its own reservation
  assign place = accept_i && is_lr && (!res_valid_q || is_owner);

  // Plain write or read-modify-write from anyone else to the reserved word
  assign foreign_store = !is_owner && (addr_i == res_addr_q) &&
                         ((we_i && !atop_i.fields.is_atomic) || is_rmw(atop_i.op));

  // SC of the presented request, used by the sequencer and response path
  assign sc_success_o = is_sc && res_valid_q && is_owner && (addr_i == res_addr_q);

  always_comb begin
    res_valid_d = res_valid_q;
    if (accept_i) begin
      if (place) begin
        res_valid_d = 1'b1;
      end
      if (foreign_store) begin
        res_valid_d = 1'b0;
      end
      // Any SC from the owner consumes the reservation
      if (is_sc && res_valid_q && is_owner) begin
        res_valid_d = 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      res_valid_q <= 1'b0;
    end else begin
      res_valid_q <= res_valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (place) begin
      res_addr_q <= addr_i;
      res_id_q   <= aid_i;
    end
  end

endmodule

//--- verilog/obi_bus_pkg.sv
// Bus definitions
// Widths, word types and the two views of the atop field
package obi_bus_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned IdWidth   = 4;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [IdWidth-1:0]   id_t;

  // Raw split of the atop field
  typedef struct packed {
    logic       is_atomic;
    logic [4:0] code;
  } atop_fields_t;

  // Same six bits seen as the full opcode or as flag plus code
  typedef union packed {
    amo_pkg::amo_op_e op;
    atop_fields_t     fields;
  } atop_u;

endpackage

//--- verilog/resp_path.sv
// Response path
// Pairs each memory response with its accepted request and patches
// in the SC result, write-back responses are dropped
`timescale 1ns/1ps

module resp_path import obi_bus_pkg::*, amo_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  accept_i,
  input  id_t   aid_i,
  input  atop_u atop_i,
  input  logic  sc_success_i,
  input  logic  mem_rvalid_i,
  input  data_t mem_rdata_i,
  output logic  rvalid_o,
  output data_t rdata_o,
  output id_t   rid_o,
  output logic  exokay_o
);

  logic pending_q;
  logic sc_q;
  logic sc_ok_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
      sc_q      <= 1'b0;
      sc_ok_q   <= 1'b0;
    end else begin
      // Memory answers one cycle after the grant
      pending_q <= accept_i;
      if (accept_i) begin
        sc_q    <= (atop_i.op == AmoSc);
        sc_ok_q <= sc_success_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept_i) begin
      rid_o <= aid_i;
    end
  end

  assign rvalid_o = pending_q & mem_rvalid_i;
  assign exokay_o = sc_q & sc_ok_q;
  assign rdata_o  = !sc_q   ? mem_rdata_i :
                    sc_ok_q ? '0          : data_t'(ScFailValue);

endmodule
